// ==== hw/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    // byte address whose low two bits stay zero for word access
    typedef logic [31:0] addr_t;

    typedef logic [31:0] word_t;

    typedef logic [2:0] miss_count_t;  // cycles spent on the current miss

    // The miss counter stops at these values. A dirty victim costs one extra
    // cycle because its write-back goes out before the refill address
    localparam miss_count_t clean_fill_count = 3'd4;
    localparam miss_count_t dirty_fill_count = 3'd5;

endpackage

`default_nettype wire

// ==== hw/request_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module request_port import cache_pkg::*; (
    input  wire   clk,
    input  wire   rst_b,

    input  wire   req,
    input  wire   we,
    input  addr_t addr,
    input  word_t wdata,
    output logic  busy,
    output logic  done,
    output word_t rdata,

    output logic  cache_en,
    output logic  cache_write_en,
    output addr_t cache_addr,
    output word_t cache_wdata,
    input  wire   hit,
    input  word_t cache_rdata
);

    typedef enum logic {
        port_idle,
        port_wait
    } port_state_t;

    port_state_t state;

    logic  we_q;
    addr_t addr_q;
    word_t wdata_q;
    logic  accept;
    logic  finish;

    assign accept = state == port_idle && req;  // req while busy is dropped
    assign finish = state == port_wait && hit;

    assign busy = state == port_wait;

    // the cache sees the request for as long as it is outstanding
    assign cache_en       = state == port_wait;
    assign cache_write_en = finish && we_q;  // lands on the same edge as a refill
    assign cache_addr     = addr_q;
    assign cache_wdata    = wdata_q;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state <= port_idle;
            done  <= 1'b0;
        end else begin
            done <= finish;
            case (state)
                port_idle: begin
                    if (accept) begin
                        state <= port_wait;
                    end
                end
                port_wait: begin
                    if (hit) begin
                        state <= port_idle;
                    end
                end
                default: state <= port_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            we_q    <= we;
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (finish) begin
            rdata <= we_q ? wdata_q : cache_rdata;  // a write echoes the stored word
        end
    end

endmodule

`default_nettype wire

// ==== hw/dm_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module dm_cache import cache_pkg::*; #(
    parameter int index_bits = 4
) (
    input  wire   clk,
    input  wire   rst_b,

    input  wire   cache_en,
    input  wire   cache_write_en,
    input  addr_t cache_addr,
    input  word_t cache_wdata,
    output logic  hit,
    output word_t cache_rdata,

    output addr_t mem_addr,
    output word_t mem_wdata,
    output logic  mem_write_en,
    input  word_t mem_rdata
);

    localparam int lines    = 1 << index_bits;
    localparam int tag_bits = 30 - index_bits;

    word_t               data_mem [lines];
    logic [tag_bits-1:0] tag_mem  [lines];
    logic [lines-1:0]    valid;
    logic [lines-1:0]    dirty;

    miss_count_t miss_count;
    miss_count_t fill_count;

    logic [index_bits-1:0] index;
    logic [tag_bits-1:0]   addr_tag;
    logic                  tag_match;
    logic                  victim_dirty;
    logic                  fill_done;
    logic                  write_back;

    // word address split into line index and tag
    assign index    = cache_addr[index_bits+1:2];
    assign addr_tag = cache_addr[31 -: tag_bits];

    assign tag_match    = valid[index] && tag_mem[index] == addr_tag;
    assign victim_dirty = valid[index] && dirty[index];

    assign fill_count = victim_dirty ? dirty_fill_count : clean_fill_count;
    assign fill_done  = !tag_match && miss_count == fill_count;

    // first miss cycle on a dirty line sends the victim out
    assign write_back = !tag_match && victim_dirty && miss_count == '0;

    // a finished miss reports hit one edge before the line is actually filled
    // so the refill and any write land together on that edge
    assign hit         = tag_match || fill_done;
    assign cache_rdata = fill_done ? mem_rdata : data_mem[index];

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            valid        <= '0;
            dirty        <= '0;
            tag_mem      <= '{default: '0};
            miss_count   <= '0;
            mem_addr     <= '0;
            mem_wdata    <= '0;
            mem_write_en <= 1'b0;
        end else if (cache_en) begin
            if (tag_match) begin
                miss_count <= '0;
            end else if (write_back) begin
                mem_addr     <= {tag_mem[index], index, 2'b00};  // rebuilt victim address
                mem_wdata    <= data_mem[index];
                mem_write_en <= 1'b1;
                miss_count   <= miss_count + 1'b1;
            end else begin
                mem_addr     <= cache_addr;
                mem_write_en <= 1'b0;
                if (fill_done) begin
                    valid[index]   <= 1'b1;
                    dirty[index]   <= 1'b0;
                    tag_mem[index] <= addr_tag;
                    miss_count     <= '0;
                end else begin
                    miss_count <= miss_count + 1'b1;
                end
            end

            if (cache_write_en) begin
                dirty[index] <= 1'b1;  // overrides the clean mark of a refill
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cache_en) begin
            if (cache_write_en) begin
                data_mem[index] <= cache_wdata;
            end else if (fill_done) begin
                data_mem[index] <= mem_rdata;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/word_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_memory import cache_pkg::*; #(
    parameter int mem_addr_bits = 10
) (
    input  wire   clk,
    input  wire   rst_b,

    input  addr_t mem_addr,
    input  word_t mem_wdata,
    input  wire   mem_write_en,
    output word_t mem_rdata
);

    localparam int words = 1 << mem_addr_bits;

    word_t mem [words];

    logic [mem_addr_bits-1:0] word_addr;

    // only the low word-address bits decode, so higher addresses alias
    assign word_addr = mem_addr[mem_addr_bits+1:2];

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            mem       <= '{default: '0};
            mem_rdata <= '0;
        end else begin
            if (mem_write_en) begin
                mem[word_addr] <= mem_wdata;
            end
            mem_rdata <= mem[word_addr];  // old word on a same-address write
        end
    end

endmodule

`default_nettype wire

// ==== hw/cache_system.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_system import cache_pkg::*; #(
    parameter int index_bits    = 4,
    parameter int mem_addr_bits = 10
) (
    input  wire   clk,
    input  wire   rst_b,

    input  wire   req,
    input  wire   we,
    input  addr_t addr,
    input  word_t wdata,
    output logic  busy,
    output logic  done,
    output word_t rdata
);

    logic  cache_en;
    logic  cache_write_en;
    addr_t cache_addr;
    word_t cache_wdata;
    logic  hit;
    word_t cache_rdata;

    addr_t mem_addr;
    word_t mem_wdata;
    logic  mem_write_en;
    word_t mem_rdata;

    request_port request_port_i (
        .clk            (clk),
        .rst_b          (rst_b),
        .req            (req),
        .we             (we),
        .addr           (addr),
        .wdata          (wdata),
        .busy           (busy),
        .done           (done),
        .rdata          (rdata),
        .cache_en       (cache_en),
        .cache_write_en (cache_write_en),
        .cache_addr     (cache_addr),
        .cache_wdata    (cache_wdata),
        .hit            (hit),
        .cache_rdata    (cache_rdata)
    );

    dm_cache #(
        .index_bits (index_bits)
    ) dm_cache_i (
        .clk            (clk),
        .rst_b          (rst_b),
        .cache_en       (cache_en),
        .cache_write_en (cache_write_en),
        .cache_addr     (cache_addr),
        .cache_wdata    (cache_wdata),
        .hit            (hit),
        .cache_rdata    (cache_rdata),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_write_en   (mem_write_en),
        .mem_rdata      (mem_rdata)
    );

    word_memory #(
        .mem_addr_bits (mem_addr_bits)
    ) word_memory_i (
        .clk          (clk),
        .rst_b        (rst_b),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_write_en (mem_write_en),
        .mem_rdata    (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_cache_vectors.svh ====
// each row holds a name, operation, byte address, write data, repeat count
// and whether a stray req is pulsed while busy
// op_rand rows draw a new write flag, address and data from the LFSR on every repeat
task automatic load_table();
    // nothing is resident after reset
    add_entry("cold_read",       op_read,  32'h0000_0040, 32'h0000_0000, 1, 1'b0);

    // line 0 now holds 0x40, both of these hit
    add_entry("hit_write",       op_write, 32'h0000_0040, 32'h1234_5678, 1, 1'b0);
    add_entry("hit_read",        op_read,  32'h0000_0040, 32'h0000_0000, 1, 1'b1);

    // 0x84 and 0xc4 share line 1 with different tags
    add_entry("evict_write_a",   op_write, 32'h0000_0084, 32'ha5a5_0001, 1, 1'b1);
    add_entry("evict_read_b",    op_read,  32'h0000_00c4, 32'h0000_0000, 1, 1'b1);
    add_entry("evict_read_a",    op_read,  32'h0000_0084, 32'h0000_0000, 1, 1'b0);

    // a write miss allocates the line
    add_entry("alloc_write",     op_write, 32'h0000_0108, 32'hc0ff_ee00, 1, 1'b0);
    add_entry("alloc_read",      op_read,  32'h0000_0108, 32'h0000_0000, 1, 1'b0);

    // 0x1108 hits the same memory word as 0x108 but carries another tag
    add_entry("alias_write",     op_write, 32'h0000_1108, 32'h0bad_cafe, 1, 1'b1);
    add_entry("alias_read_low",  op_read,  32'h0000_0108, 32'h0000_0000, 1, 1'b0);
    add_entry("alias_read_high", op_read,  32'h0000_1108, 32'h0000_0000, 1, 1'b0);

    add_entry("random_mix",      op_rand,  32'h0000_0000, 32'h0000_0000, 48, 1'b0);
    add_entry("random_poke",     op_rand,  32'h0000_0000, 32'h0000_0000, 8, 1'b1);

    // earlier words must have survived the random traffic
    add_entry("final_read_a",    op_read,  32'h0000_0084, 32'h0000_0000, 1, 1'b0);
    add_entry("final_read_alias", op_read, 32'h0000_0108, 32'h0000_0000, 1, 1'b0);
endtask

// ==== testbench/tb_cache_system.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cache_system;

    localparam int half_period    = 50;
    localparam int timeout_cycles = 20;
    localparam int max_entries    = 32;

    localparam int op_read  = 0;
    localparam int op_write = 1;
    localparam int op_rand  = 2;  // write flag, address and data come from the LFSR

    logic        clk;
    logic        rst_b;
    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
    wire         busy;
    wire         done;
    wire  [31:0] rdata;

    string       tab_name   [max_entries];
    int          tab_op     [max_entries];
    logic [31:0] tab_addr   [max_entries];
    logic [31:0] tab_data   [max_entries];
    int          tab_repeat [max_entries];
    logic        tab_poke   [max_entries];
    int          tab_count = 0;

    // flat view of memory plus the line state a direct-mapped cache must have
    logic [31:0] ref_mem      [1024];
    logic [25:0] shadow_tag   [16];
    logic        shadow_valid [16];
    logic        shadow_dirty [16];

    logic [31:0] lfsr_state;
    logic        timed_out   = 1'b0;
    int          error_count = 0;
    int          test_count  = 0;
    int          ok_count    = 0;
    int          accepted    = 0;
    int          done_count  = 0;

    cache_system #(
        .index_bits    (4),
        .mem_addr_bits (10)
    ) cache_system_i (
        .clk   (clk),
        .rst_b (rst_b),
        .req   (req),
        .we    (we),
        .addr  (addr),
        .wdata (wdata),
        .busy  (busy),
        .done  (done),
        .rdata (rdata)
    );

    initial clk = 1'b0;
    always #(half_period) clk = ~clk;

    always @(negedge clk) begin
        if (rst_b && done) begin
            done_count = done_count + 1;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'hb4bc_d35c;
        end
        return state >> 1;
    endfunction

    // one step of the register for every bit handed out
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return value;
    endfunction

    task automatic add_entry(input string name, input int op, input logic [31:0] a,
                             input logic [31:0] d, input int reps, input logic poke);
        if (tab_count >= max_entries) begin
            $display("table full, entry %s was not added", name);
            error_count++;
        end else begin
            tab_name[tab_count]   = name;
            tab_op[tab_count]     = op;
            tab_addr[tab_count]   = a;
            tab_data[tab_count]   = d;
            tab_repeat[tab_count] = reps;
            tab_poke[tab_count]   = poke;
            tab_count++;
        end
    endtask

    `include "tb_cache_vectors.svh"

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s %s: expected 0x%0h, actual 0x%0h", name, what, expected, actual);
            error_count++;
        end
    endtask

    // 1 for a resident line, 6 when a dirty victim goes out first, else 5
    function automatic int expected_latency(input logic [31:0] a);
        logic [3:0] idx;
        idx = a[5:2];
        if (shadow_valid[idx] && shadow_tag[idx] == a[31:6]) begin
            return 1;
        end
        if (shadow_valid[idx] && shadow_dirty[idx]) begin
            return 6;
        end
        return 5;
    endfunction

    task automatic update_model(input logic w, input logic [31:0] a, input logic [31:0] d);
        logic [3:0] idx;
        idx = a[5:2];
        if (!(shadow_valid[idx] && shadow_tag[idx] == a[31:6])) begin
            shadow_valid[idx] = 1'b1;  // refilled clean
            shadow_tag[idx]   = a[31:6];
            shadow_dirty[idx] = 1'b0;
        end
        if (w) begin
            shadow_dirty[idx] = 1'b1;
            ref_mem[a[11:2]]  = d;
        end
    endtask

    // starts and ends on a falling edge
    task automatic run_request(input string name, input logic w, input logic [31:0] a,
                               input logic [31:0] d, input logic poke);
        logic [31:0] expected_data;
        int          expected_lat;
        int          cycles;
        int          errors_before;
        logic        seen_done;

        expected_lat  = expected_latency(a);
        expected_data = w ? d : ref_mem[a[11:2]];
        errors_before = error_count;
        cycles        = 0;
        seen_done     = 1'b0;

        req   = 1'b1;
        we    = w;
        addr  = a;
        wdata = d;
        @(negedge clk);
        check_value(name, "busy after accept", 32'd1, {31'b0, busy});
        if (poke) begin
            we    = 1'b1;  // a stray write while busy must leave no trace
            addr  = a ^ 32'h0000_0040;
            wdata = 32'hdead_beef;
        end else begin
            req = 1'b0;
        end

        while (!seen_done && cycles < timeout_cycles) begin
            @(negedge clk);
            req = 1'b0;
            cycles++;
            if (done) begin
                seen_done = 1'b1;
            end else begin
                check_value(name, "busy while waiting", 32'd1, {31'b0, busy});
            end
        end

        if (!seen_done) begin
            $display("timeout: %s saw no done within %0d cycles", name, timeout_cycles);
            timed_out = 1'b1;
            error_count++;
        end else begin
            check_value(name, "latency", expected_lat, cycles);
            check_value(name, "read data", expected_data, rdata);
            check_value(name, "busy at done", 32'd0, {31'b0, busy});
        end

        accepted++;
        update_model(w, a, d);
        test_count++;
        if (error_count == errors_before) begin
            ok_count++;
        end
        $display("test %-18s %s 0x%08h latency %0d: %s", name, w ? "write" : "read ",
                 a, cycles, error_count == errors_before ? "ok" : "errors");
    endtask

    initial begin
        string       name;
        logic [31:0] rand_bits;
        logic        w;
        logic [31:0] a;
        logic [31:0] d;

        req        = 1'b0;
        we         = 1'b0;
        addr       = '0;
        wdata      = '0;
        rst_b      = 1'b0;
        lfsr_state = 32'd40;
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            shadow_tag[i]   = '0;
            shadow_valid[i] = 1'b0;
            shadow_dirty[i] = 1'b0;
        end
        load_table();

        repeat (4) @(negedge clk);
        rst_b = 1'b1;
        @(negedge clk);

        for (int e = 0; e < tab_count && !timed_out; e++) begin
            for (int r = 0; r < tab_repeat[e] && !timed_out; r++) begin
                if (tab_op[e] == op_rand) begin
                    rand_bits = draw_bits(1);
                    w         = rand_bits[0];
                    rand_bits = draw_bits(6);
                    a         = {24'h0, rand_bits[5:0], 2'b00};  // 64 words, 4 tags per line
                    d         = '0;
                    if (w) begin
                        d = draw_bits(32);
                    end
                    name = $sformatf("%s_%0d", tab_name[e], r);
                end else begin
                    w    = tab_op[e] == op_write;
                    a    = tab_addr[e];
                    d    = tab_data[e];
                    name = tab_name[e];
                end
                run_request(name, w, a, d, tab_poke[e]);
            end
        end

        // room for a late done from a stray req
        repeat (4) @(negedge clk);
        @(posedge clk);
        if (!timed_out) begin
            check_value("done_pulses", "count", accepted, done_count);
        end

        $display("summary: %0d tests, %0d ok, %0d errors, %0d done pulses for %0d requests",
                 test_count, ok_count, error_count, done_count, accepted);
        if (error_count == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+testbench
hw/cache_pkg.sv
hw/request_port.sv
hw/dm_cache.sv
hw/word_memory.sv
hw/cache_system.sv
testbench/tb_cache_system.sv

// ==== run_sim.sh ====
#!/bin/sh
# build from the file list, run, and judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_cache_system -f tb.f -o tb_cache_system \
    && ./obj_dir/tb_cache_system > sim.log 2>&1 \
    || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "TESTBENCH PASSED" sim.log && exit 0 || exit 1
